// File: run_sim.sh
#!/bin/sh
# build and run the peripheral subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --timescale 1ns/10ps \
   --top-module tb_soc_periph \
   -Mdir obj_dir -o sim_soc_periph \
   -f src.f

./obj_dir/sim_soc_periph | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi

echo "simulation passed"

// File: source/bus_decode.sv
`timescale 1ns/10ps

module bus_decode (
   input  logic                       clk,
   input  logic                       rst_n,
   input  soc_pkg::bus_req_t          bus_req,
   input  soc_pkg::word_t             ram_rdata,
   input  soc_pkg::word_t             mtime,
   input  soc_pkg::word_t             mtimecmp,
   input  soc_pkg::byte_t             rx_hold,
   input  soc_pkg::uart_status_t      uart_status,
   output logic [soc_pkg::RAM_AW-1:0] ram_addr,
   output logic                       ram_we,
   output logic                       mtime_we,
   output logic                       mtimecmp_we,
   output logic                       tx_wr,
   output logic                       data_rd,
   output soc_pkg::word_t             rdata
);

   soc_pkg::region_e region;
   // region and sampled word of the last read
   soc_pkg::region_e rd_region_q;
   soc_pkg::word_t   samp_d;
   soc_pkg::word_t   samp_q;
   // high for the one cycle after a read edge
   logic             rd_fresh_q;
   // keeps rdata steady between reads
   soc_pkg::word_t   hold_q;

   // zero upper half selects the ram aliased every 8 KiB
   always_comb
   begin
      if (bus_req.addr[31:16] == 16'h0000)
         region = soc_pkg::REGION_RAM;
      else if (bus_req.addr == soc_pkg::ADDR_MTIME)
         region = soc_pkg::REGION_MTIME;
      else if (bus_req.addr == soc_pkg::ADDR_MTIMECMP)
         region = soc_pkg::REGION_MTIMECMP;
      else if (bus_req.addr == soc_pkg::ADDR_UART_DATA)
         region = soc_pkg::REGION_UART_DATA;
      else if (bus_req.addr == soc_pkg::ADDR_UART_STAT)
         region = soc_pkg::REGION_UART_STAT;
      else
         region = soc_pkg::REGION_NONE;
   end

   // word address without the byte lanes
   assign ram_addr = bus_req.addr[soc_pkg::RAM_AW+1:2];

   // per-region strobes
   assign ram_we      = bus_req.we && (region == soc_pkg::REGION_RAM);
   assign mtime_we    = bus_req.we && (region == soc_pkg::REGION_MTIME);
   assign mtimecmp_we = bus_req.we && (region == soc_pkg::REGION_MTIMECMP);
   assign tx_wr       = bus_req.we && (region == soc_pkg::REGION_UART_DATA);
   assign data_rd     = bus_req.re && (region == soc_pkg::REGION_UART_DATA);

   // register values captured at the read edge
   always_comb
   begin
      case (region)
         soc_pkg::REGION_MTIME:     samp_d = mtime;
         soc_pkg::REGION_MTIMECMP:  samp_d = mtimecmp;
         soc_pkg::REGION_UART_DATA: samp_d = {{(soc_pkg::XLEN-8){1'b0}}, rx_hold};
         soc_pkg::REGION_UART_STAT: samp_d = {{(soc_pkg::XLEN-2){1'b0}}, uart_status};
         // ram word comes from the ram read stage
         // unmapped reads return zero
         default:                   samp_d = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_fresh_q  <= 1'b0;
         rd_region_q <= soc_pkg::REGION_NONE;
         hold_q      <= '0;
      end
      else
      begin
         rd_fresh_q <= bus_req.re;
         if (bus_req.re)
            rd_region_q <= region;
         // freeze whatever went out on the fresh cycle
         if (rd_fresh_q)
            hold_q <= rdata;
      end
   end

   // register word sampled at the read edge
   always_ff @(posedge clk)
   begin
      if (bus_req.re)
         samp_q <= samp_d;
   end

   // one cycle latency for all regions
   always_comb
   begin
      if (!rd_fresh_q)
         rdata = hold_q;
      else if (rd_region_q == soc_pkg::REGION_RAM)
         rdata = ram_rdata;
      else
         rdata = samp_q;
   end

   // core never issues both strobes
   a_we_re_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(bus_req.we && bus_req.re))
      else $error("we and re together");

endmodule

// File: source/data_ram.sv
`timescale 1ns/10ps

module data_ram (
   input  logic                       clk,
   input  logic [soc_pkg::RAM_AW-1:0] addr,
   input  logic                       we,
   input  soc_pkg::word_t             wdata,
   output soc_pkg::word_t             rdata
);

   // 2048 words, no reset on contents
   soc_pkg::word_t mem [0:(1 << soc_pkg::RAM_AW)-1];

   // single port, sync write
   always_ff @(posedge clk)
   begin
      if (we)
         mem[addr] <= wdata;
   end

   // registered read, write-first on the same port
   always_ff @(posedge clk)
   begin
      if (we)
         rdata <= wdata;
      else
         rdata <= mem[addr];
   end

endmodule

// File: source/soc_periph_top.sv
`timescale 1ns/10ps

module soc_periph_top (
   input  logic              clk,
   input  logic              rst_n,
   input  soc_pkg::bus_req_t bus_req,
   input  logic              mtie,
   input  logic              meie,
   input  logic              uart_rxd,
   output soc_pkg::word_t    rdata,
   output logic              tmr_irq,
   output logic              ext_irq,
   output logic              uart_txd
);

   // ram side
   logic [soc_pkg::RAM_AW-1:0] ram_addr;
   logic                       ram_we;
   soc_pkg::word_t             ram_rdata;

   // timer side
   logic           mtime_we;
   logic           mtimecmp_we;
   soc_pkg::word_t mtime;
   soc_pkg::word_t mtimecmp;

   // uart side
   logic                  tx_wr;
   logic                  data_rd;
   logic                  tx_start;
   logic                  tx_busy;
   soc_pkg::byte_t        tx_byte;
   soc_pkg::byte_t        rx_byte;
   logic                  rx_strobe;
   soc_pkg::byte_t        rx_hold;
   soc_pkg::uart_status_t uart_status;

   // tx character is the low byte of the write data
   assign tx_byte = bus_req.wdata[7:0];

   bus_decode bus_decode_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .bus_req     (bus_req),
      .ram_rdata   (ram_rdata),
      .mtime       (mtime),
      .mtimecmp    (mtimecmp),
      .rx_hold     (rx_hold),
      .uart_status (uart_status),
      .ram_addr    (ram_addr),
      .ram_we      (ram_we),
      .mtime_we    (mtime_we),
      .mtimecmp_we (mtimecmp_we),
      .tx_wr       (tx_wr),
      .data_rd     (data_rd),
      .rdata       (rdata)
   );

   data_ram data_ram_inst (
      .clk   (clk),
      .addr  (ram_addr),
      .we    (ram_we),
      .wdata (bus_req.wdata),
      .rdata (ram_rdata)
   );

   timer_lic timer_lic_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .wdata       (bus_req.wdata),
      .mtime_we    (mtime_we),
      .mtimecmp_we (mtimecmp_we),
      .mtie        (mtie),
      .mtime       (mtime),
      .mtimecmp    (mtimecmp),
      .tmr_irq     (tmr_irq)
   );

   uart_regs uart_regs_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .tx_wr       (tx_wr),
      .tx_byte     (tx_byte),
      .data_rd     (data_rd),
      .rx_byte     (rx_byte),
      .rx_strobe   (rx_strobe),
      .tx_busy     (tx_busy),
      .meie        (meie),
      .tx_start    (tx_start),
      .rx_hold     (rx_hold),
      .uart_status (uart_status),
      .ext_irq     (ext_irq)
   );

   uart_phy uart_phy_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .tx_start  (tx_start),
      .tx_byte   (tx_byte),
      .rxd       (uart_rxd),
      .txd       (uart_txd),
      .tx_busy   (tx_busy),
      .rx_byte   (rx_byte),
      .rx_strobe (rx_strobe)
   );

endmodule

// File: source/soc_pkg.sv
package soc_pkg;

   // bus word width
   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   // one uart character
   typedef logic [7:0] byte_t;

   // ram word address bits, 2048 words
   localparam int RAM_AW = 11;

   // exact-match peripheral registers
   localparam word_t ADDR_MTIME     = 32'h0002_0000;
   localparam word_t ADDR_MTIMECMP  = 32'h0002_0008;
   localparam word_t ADDR_UART_DATA = 32'h0002_1000;
   localparam word_t ADDR_UART_STAT = 32'h0002_1004;

   // clocks per serial bit
   localparam int BAUD_DIV = 8;
   localparam int BAUD_CW  = $clog2(BAUD_DIV);

   typedef logic [BAUD_CW-1:0] baud_cnt_t;

   // last cycle of a bit, and the cycle that lands mid start bit
   localparam baud_cnt_t BAUD_LAST = BAUD_CW'(BAUD_DIV - 1);
   localparam baud_cnt_t BAUD_HALF = BAUD_CW'(BAUD_DIV / 2 - 1);

   // data-side bus from the core
   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  we;
      logic  re;
   } bus_req_t;

   typedef enum logic [2:0] {
      REGION_RAM,
      REGION_MTIME,
      REGION_MTIMECMP,
      REGION_UART_DATA,
      REGION_UART_STAT,
      REGION_NONE
   } region_e;

   // shared by tx and rx machines
   typedef enum logic [1:0] {
      UART_IDLE,
      UART_START,
      UART_DATA,
      UART_STOP
   } uart_state_e;

   // tx_busy lands on bit 0 of the read word
   typedef struct packed {
      logic rx_pending;
      logic tx_busy;
   } uart_status_t;

endpackage

// File: source/timer_lic.sv
`timescale 1ns/10ps

module timer_lic (
   input  logic           clk,
   input  logic           rst_n,
   input  soc_pkg::word_t wdata,
   input  logic           mtime_we,
   input  logic           mtimecmp_we,
   input  logic           mtie,
   output soc_pkg::word_t mtime,
   output soc_pkg::word_t mtimecmp,
   output logic           tmr_irq
);

   logic cmp_hit;

   // unsigned compare
   assign cmp_hit = (mtime >= mtimecmp);

   // free-running counter
   // a bus write beats the increment
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         mtime <= '0;
      else if (mtime_we)
         mtime <= wdata;
      else
         mtime <= mtime + 1'b1;
   end

   // all ones keeps the irq off after reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         mtimecmp <= '1;
      else if (mtimecmp_we)
         mtimecmp <= wdata;
   end

   // irq one cycle behind the compare
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         tmr_irq <= 1'b0;
      else
         tmr_irq <= cmp_hit && mtie;
   end

endmodule

// File: source/uart_phy.sv
`timescale 1ns/10ps

module uart_phy (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           tx_start,
   input  soc_pkg::byte_t tx_byte,
   input  logic           rxd,
   output logic           txd,
   output logic           tx_busy,
   output soc_pkg::byte_t rx_byte,
   output logic           rx_strobe
);

   // transmitter
   soc_pkg::uart_state_e tx_state;
   soc_pkg::baud_cnt_t   tx_cnt;
   logic [2:0]           tx_idx;
   soc_pkg::byte_t       tx_sh;

   // receiver
   soc_pkg::uart_state_e rx_state;
   soc_pkg::baud_cnt_t   rx_cnt;
   logic [2:0]           rx_idx;
   logic                 rxd_s1;
   logic                 rxd_s2;

   // busy until the stop bit has run out
   assign tx_busy = (tx_state != soc_pkg::UART_IDLE);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         tx_state <= soc_pkg::UART_IDLE;
         tx_cnt   <= '0;
         tx_idx   <= '0;
         txd      <= 1'b1;
      end
      else
      begin
         case (tx_state)
            soc_pkg::UART_IDLE:
            begin
               // start bit goes out right after the accept edge
               if (tx_start)
               begin
                  tx_state <= soc_pkg::UART_START;
                  tx_cnt   <= '0;
                  txd      <= 1'b0;
               end
            end
            soc_pkg::UART_START:
            begin
               if (tx_cnt == soc_pkg::BAUD_LAST)
               begin
                  tx_state <= soc_pkg::UART_DATA;
                  tx_cnt   <= '0;
                  tx_idx   <= '0;
                  // lsb first
                  txd      <= tx_sh[0];
               end
               else
                  tx_cnt <= tx_cnt + 1'b1;
            end
            soc_pkg::UART_DATA:
            begin
               if (tx_cnt == soc_pkg::BAUD_LAST)
               begin
                  tx_cnt <= '0;
                  if (tx_idx == 3'd7)
                  begin
                     tx_state <= soc_pkg::UART_STOP;
                     txd      <= 1'b1;
                  end
                  else
                  begin
                     tx_idx <= tx_idx + 1'b1;
                     txd    <= tx_sh[tx_idx + 1'b1];
                  end
               end
               else
                  tx_cnt <= tx_cnt + 1'b1;
            end
            default:
            begin
               // stop bit, line stays high
               if (tx_cnt == soc_pkg::BAUD_LAST)
                  tx_state <= soc_pkg::UART_IDLE;
               else
                  tx_cnt <= tx_cnt + 1'b1;
            end
         endcase
      end
   end

   // tx character, loaded once per frame
   always_ff @(posedge clk)
   begin
      if (tx_start && !tx_busy)
         tx_sh <= tx_byte;
   end

   // two-flop sync, idles high
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rxd_s1 <= 1'b1;
         rxd_s2 <= 1'b1;
      end
      else
      begin
         rxd_s1 <= rxd;
         rxd_s2 <= rxd_s1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rx_state  <= soc_pkg::UART_IDLE;
         rx_cnt    <= '0;
         rx_idx    <= '0;
         rx_strobe <= 1'b0;
      end
      else
      begin
         rx_strobe <= 1'b0;
         case (rx_state)
            soc_pkg::UART_IDLE:
            begin
               // falling edge of the start bit
               if (!rxd_s2)
               begin
                  rx_state <= soc_pkg::UART_START;
                  rx_cnt   <= '0;
               end
            end
            soc_pkg::UART_START:
            begin
               // recheck at mid start bit, glitches fall back to idle
               if (rx_cnt == soc_pkg::BAUD_HALF)
               begin
                  rx_cnt   <= '0;
                  rx_idx   <= '0;
                  rx_state <= rxd_s2 ? soc_pkg::UART_IDLE : soc_pkg::UART_DATA;
               end
               else
                  rx_cnt <= rx_cnt + 1'b1;
            end
            soc_pkg::UART_DATA:
            begin
               // one full bit later is mid data bit
               if (rx_cnt == soc_pkg::BAUD_LAST)
               begin
                  rx_cnt <= '0;
                  rx_idx <= rx_idx + 1'b1;
                  if (rx_idx == 3'd7)
                     rx_state <= soc_pkg::UART_STOP;
               end
               else
                  rx_cnt <= rx_cnt + 1'b1;
            end
            default:
            begin
               // framing error drops the byte
               if (rx_cnt == soc_pkg::BAUD_LAST)
               begin
                  rx_state  <= soc_pkg::UART_IDLE;
                  rx_strobe <= rxd_s2;
               end
               else
                  rx_cnt <= rx_cnt + 1'b1;
            end
         endcase
      end
   end

   // shift in from the top, lsb ends at bit 0
   always_ff @(posedge clk)
   begin
      if (rx_state == soc_pkg::UART_DATA && rx_cnt == soc_pkg::BAUD_LAST)
         rx_byte <= {rxd_s2, rx_byte[7:1]};
   end

   // register block must hold off starts while a frame is out
   a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
      tx_start |-> !tx_busy)
      else $error("tx_start while busy");

endmodule

// File: source/uart_regs.sv
`timescale 1ns/10ps

module uart_regs (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  tx_wr,
   input  soc_pkg::byte_t        tx_byte,
   input  logic                  data_rd,
   input  soc_pkg::byte_t        rx_byte,
   input  logic                  rx_strobe,
   input  logic                  tx_busy,
   input  logic                  meie,
   output logic                  tx_start,
   output soc_pkg::byte_t        rx_hold,
   output soc_pkg::uart_status_t uart_status,
   output logic                  ext_irq
);

   logic rx_pending;

   // writes while busy are lost
   assign tx_start = tx_wr && !tx_busy;

   // last received byte, a newer one overwrites
   always_ff @(posedge clk)
   begin
      if (rx_strobe)
         rx_hold <= rx_byte;
   end

   // strobe beats a same-cycle read
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rx_pending <= 1'b0;
      else if (rx_strobe)
         rx_pending <= 1'b1;
      else if (data_rd)
         rx_pending <= 1'b0;
   end

   assign uart_status.tx_busy    = tx_busy;
   assign uart_status.rx_pending = rx_pending;

   // pending masked by meie
   assign ext_irq = rx_pending && meie;

   // serializer loads this byte at the start edge
   a_tx_byte_known: assert property (@(posedge clk) disable iff (!rst_n)
      tx_start |-> !$isunknown(tx_byte))
      else $error("tx byte unknown at start");

endmodule

// File: src.f
source/soc_pkg.sv
source/bus_decode.sv
source/data_ram.sv
source/timer_lic.sv
source/uart_regs.sv
source/uart_phy.sv
source/soc_periph_top.sv
verif/tb_soc_periph.sv

// File: verif/tb_soc_periph.sv
`timescale 1ns/10ps

module tb_soc_periph;

   logic                  clk = 1'b0;
   logic                  rst_n;
   soc_pkg::bus_req_t     bus_req;
   logic                  mtie;
   logic                  meie;
   logic                  uart_rxd;
   soc_pkg::word_t        rdata;
   logic                  tmr_irq;
   logic                  ext_irq;
   logic                  uart_txd;

   // scoreboard counts
   int errors = 0;
   int checks = 0;
   int test_err;
   // edge counter for mtime read windows
   int cyc = 0;
   int rst_cyc;
   int wr_cyc;
   int rd_cyc;
   // last value written to each ram word
   soc_pkg::word_t ram_model [0:(1 << soc_pkg::RAM_AW)-1];

   always #4 clk = ~clk;

   always @(posedge clk)
      cyc <= cyc + 1;

   soc_periph_top soc_periph_top_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus_req  (bus_req),
      .mtie     (mtie),
      .meie     (meie),
      .uart_rxd (uart_rxd),
      .rdata    (rdata),
      .tmr_irq  (tmr_irq),
      .ext_irq  (ext_irq),
      .uart_txd (uart_txd)
   );

   task automatic check_word(input string name, input soc_pkg::word_t got,
                             input soc_pkg::word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_byte(input string name, input soc_pkg::byte_t got,
                             input soc_pkg::byte_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // mtime keeps counting so only a window is known
   task automatic check_range(input string name, input soc_pkg::word_t got,
                              input soc_pkg::word_t lo, input soc_pkg::word_t hi);
      checks++;
      if (got < lo || got > hi)
      begin
         errors++;
         $display("ERROR %0t %s got %h expected %h to %h", $time, name, got, lo, hi);
      end
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("%0t: %s", $time, what);
   endtask

   // one-cycle strobe sampled at the following edge
   task automatic bus_write(input soc_pkg::word_t addr, input soc_pkg::word_t data);
      @(posedge clk);
      bus_req.addr  <= addr;
      bus_req.wdata <= data;
      bus_req.we    <= 1'b1;
      @(posedge clk);
      wr_cyc = cyc;
      bus_req.we <= 1'b0;
   endtask

   // rdata is valid for the cycle after the sampled edge
   task automatic bus_read(input soc_pkg::word_t addr, output soc_pkg::word_t data);
      @(posedge clk);
      bus_req.addr <= addr;
      bus_req.re   <= 1'b1;
      @(posedge clk);
      rd_cyc = cyc;
      bus_req.re <= 1'b0;
      @(negedge clk);
      data = rdata;
   endtask

   // 8N1 frame sent lsb first
   task automatic send_serial(input soc_pkg::byte_t data);
      logic [9:0] frame;
      int         i;
      frame = {1'b1, data, 1'b0};
      for (i = 0; i < 10; i++)
      begin
         @(posedge clk);
         uart_rxd <= frame[i];
         repeat (soc_pkg::BAUD_DIV - 1) @(posedge clk);
      end
   endtask

   task automatic capture_serial(output soc_pkg::byte_t data, output bit found);
      int waited;
      int i;
      data   = '0;
      found  = 1'b0;
      waited = 0;
      while (uart_txd !== 1'b0 && waited < 8 * soc_pkg::BAUD_DIV)
      begin
         @(negedge clk);
         waited++;
      end
      if (uart_txd === 1'b0)
      begin
         found = 1'b1;
         // near the middle of the start bit
         repeat (soc_pkg::BAUD_DIV / 2 - 1) @(negedge clk);
         check_bit("uart_txd start bit", uart_txd, 1'b0);
         for (i = 0; i < 8; i++)
         begin
            repeat (soc_pkg::BAUD_DIV) @(negedge clk);
            data[i] = uart_txd;
         end
         repeat (soc_pkg::BAUD_DIV) @(negedge clk);
         check_bit("uart_txd stop bit", uart_txd, 1'b1);
      end
   endtask

   // poll one of the irq lines at negedges
   task automatic wait_irq(input bit ext, input int limit, output bit seen);
      int n;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < limit)
      begin
         @(negedge clk);
         seen = ext ? ext_irq : tmr_irq;
         n++;
      end
   endtask

   // polled through the status register
   task automatic wait_rx_pending(output bit seen);
      soc_pkg::word_t st;
      int             n;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < 16)
      begin
         bus_read(soc_pkg::ADDR_UART_STAT, st);
         seen = st[1];
         n++;
      end
   endtask

   task test_reset_state();
      soc_pkg::word_t got;
      test_err = errors;
      check_bit("tmr_irq", tmr_irq, 1'b0);
      check_bit("ext_irq", ext_irq, 1'b0);
      check_bit("uart_txd", uart_txd, 1'b1);
      check_word("rdata", rdata, '0);
      // mtime restarted from zero at the release edge
      bus_read(soc_pkg::ADDR_MTIME, got);
      check_range("mtime", got, '0, soc_pkg::word_t'(rd_cyc - rst_cyc));
      bus_read(soc_pkg::ADDR_MTIMECMP, got);
      check_word("mtimecmp", got, '1);
      bus_write(32'h0000_0000, 32'h1234_5678);
      // unmapped and between-register writes
      bus_write(32'h0003_0000, $urandom);
      bus_write(32'h0002_0004, $urandom);
      bus_read(32'h0000_0000, got);
      check_word("ram[0]", got, 32'h1234_5678);
      bus_read(soc_pkg::ADDR_MTIMECMP, got);
      check_word("mtimecmp", got, '1);
      check_bit("uart_txd", uart_txd, 1'b1);
      // mtime still counting from reset
      bus_read(soc_pkg::ADDR_MTIME, got);
      check_range("mtime after unmapped writes", got, '0,
                  soc_pkg::word_t'(rd_cyc - rst_cyc));
      bus_read(32'h0003_0000, got);
      check_word("rdata at 0x00030000", got, '0);
      bus_read(32'h0002_0004, got);
      check_word("rdata at 0x00020004", got, '0);
      $display("test reset_unmapped done, %0d errors", errors - test_err);
   endtask

   task test_ram();
      logic [soc_pkg::RAM_AW-1:0] idx;
      logic [soc_pkg::RAM_AW-1:0] idx_q[$];
      soc_pkg::word_t             val;
      soc_pkg::word_t             got;
      int                         i;
      test_err = errors;
      for (i = 0; i < 32; i++)
      begin
         idx = soc_pkg::RAM_AW'($urandom);
         val = $urandom;
         ram_model[idx] = val;
         idx_q.push_back(idx);
         bus_write(soc_pkg::word_t'({idx, 2'b00}), val);
      end
      // repeated words expect the later value
      for (i = 0; i < idx_q.size(); i++)
      begin
         bus_read(soc_pkg::word_t'({idx_q[i], 2'b00}), got);
         check_word($sformatf("ram[%0d]", idx_q[i]), got, ram_model[idx_q[i]]);
      end
      // 8 KiB alias
      idx = soc_pkg::RAM_AW'($urandom);
      val = $urandom;
      bus_write(soc_pkg::word_t'({idx, 2'b00}) + 32'h2000, val);
      bus_read(soc_pkg::word_t'({idx, 2'b00}), got);
      check_word($sformatf("ram[%0d] alias", idx), got, val);
      $display("test ram done, %0d errors", errors - test_err);
   endtask

   task test_timer();
      soc_pkg::word_t v;
      soc_pkg::word_t cmp;
      soc_pkg::word_t got;
      bit             seen;
      test_err = errors;
      v = $urandom & 32'h0fff_ffff;
      bus_write(soc_pkg::ADDR_MTIME, v);
      repeat (3) @(posedge clk);
      bus_read(soc_pkg::ADDR_MTIME, got);
      check_range("mtime", got, v, v + soc_pkg::word_t'(rd_cyc - wr_cyc));
      // large compare value well above mtime
      cmp = $urandom | 32'h8000_0000;
      bus_write(soc_pkg::ADDR_MTIMECMP, cmp);
      bus_read(soc_pkg::ADDR_MTIMECMP, got);
      check_word("mtimecmp", got, cmp);
      // compare point a little ahead of mtime
      bus_read(soc_pkg::ADDR_MTIME, got);
      bus_write(soc_pkg::ADDR_MTIMECMP, got + 32'd48);
      @(posedge clk);
      mtie <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_bit("tmr_irq", tmr_irq, 1'b0);
      wait_irq(1'b0, 200, seen);
      if (!seen)
         note_failure("tmr_irq never rose after mtime passed mtimecmp");
      @(posedge clk);
      mtie <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      check_bit("tmr_irq after mtie low", tmr_irq, 1'b0);
      // compare parked at all ones
      bus_write(soc_pkg::ADDR_MTIMECMP, '1);
      @(posedge clk);
      mtie <= 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_bit("tmr_irq with mtimecmp all ones", tmr_irq, 1'b0);
      @(posedge clk);
      mtie <= 1'b0;
      $display("test timer done, %0d errors", errors - test_err);
   endtask

   task test_uart_tx();
      soc_pkg::byte_t b;
      soc_pkg::byte_t got_b;
      soc_pkg::word_t got;
      bit             found;
      bit             idle;
      int             i;
      test_err = errors;
      b = soc_pkg::byte_t'($urandom);
      fork
         capture_serial(got_b, found);
         begin
            bus_write(soc_pkg::ADDR_UART_DATA, {24'h0, b});
            bus_read(soc_pkg::ADDR_UART_STAT, got);
            check_bit("tx_busy", got[0], 1'b1);
            // lands while the frame is still going out
            bus_write(soc_pkg::ADDR_UART_DATA, {24'h0, ~b});
         end
      join
      if (!found)
         note_failure("no start bit on uart_txd after a transmit write");
      else
         check_byte("uart_txd frame", got_b, b);
      // no frame may follow for the dropped byte
      idle = 1'b1;
      for (i = 0; i < 4 * soc_pkg::BAUD_DIV; i++)
      begin
         @(negedge clk);
         if (uart_txd !== 1'b1)
            idle = 1'b0;
      end
      if (!idle)
         note_failure("uart_txd left idle after the frame, a dropped write was sent");
      bus_read(soc_pkg::ADDR_UART_STAT, got);
      check_bit("tx_busy", got[0], 1'b0);
      $display("test uart_tx done, %0d errors", errors - test_err);
   endtask

   task test_uart_rx(input bit irq_en);
      soc_pkg::byte_t b;
      soc_pkg::word_t got;
      bit             seen;
      test_err = errors;
      b = soc_pkg::byte_t'($urandom);
      @(posedge clk);
      meie <= irq_en;
      send_serial(b);
      if (irq_en)
      begin
         wait_irq(1'b1, 4 * soc_pkg::BAUD_DIV, seen);
         if (!seen)
            note_failure("ext_irq never rose after a received byte");
      end
      else
      begin
         wait_rx_pending(seen);
         if (!seen)
            note_failure("rx_pending never set after a received byte");
         check_bit("ext_irq with meie low", ext_irq, 1'b0);
      end
      bus_read(soc_pkg::ADDR_UART_STAT, got);
      check_bit("rx_pending", got[1], 1'b1);
      // data read clears pending at its edge
      bus_read(soc_pkg::ADDR_UART_DATA, got);
      check_word("uart data", got, {24'h0, b});
      check_bit("ext_irq", ext_irq, 1'b0);
      bus_read(soc_pkg::ADDR_UART_STAT, got);
      check_bit("rx_pending", got[1], 1'b0);
      $display("test uart_rx meie=%0b done, %0d errors", irq_en, errors - test_err);
   endtask

   initial
   begin
      void'($urandom(32'hd56f_4020));
      rst_n    <= 1'b0;
      bus_req  <= '0;
      mtie     <= 1'b0;
      meie     <= 1'b0;
      uart_rxd <= 1'b1;
      repeat (16) @(posedge clk);
      // last edge that still sees reset
      rst_cyc = cyc;
      rst_n <= 1'b1;
      @(negedge clk);
      test_reset_state();
      test_ram();
      test_timer();
      test_uart_tx();
      test_uart_rx(1'b1);
      test_uart_rx(1'b0);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule
